//--- Bender.yml
package:
  name: msx_io

sources:
  - hw/msx_bus_pkg.sv
  - hw/msx_ppi_pkg.sv
  - hw/msx_io_decoder.sv
  - hw/msx_ppi.sv
  - hw/msx_key_matrix.sv
  - hw/msx_slot_select.sv
  - hw/msx_io_top.sv
  - target: test
    files:
      - test/tb_msx_io.sv

//--- flist.f
hw/msx_bus_pkg.sv
hw/msx_ppi_pkg.sv
hw/msx_io_decoder.sv
hw/msx_ppi.sv
hw/msx_key_matrix.sv
hw/msx_slot_select.sv
hw/msx_io_top.sv
test/tb_msx_io.sv

//--- hw/msx_bus_pkg.sv
package msx_bus_pkg;

   // Z80 bus widths
   localparam int ADDR_W = 16;
   localparam int DATA_W = 8;

   // I/O cycles only look at the low address byte
   localparam int PORT_W = 8;

   // PPI decode covers port bits 7:3
   // A2 is ignored, so A8h-ABh mirror at ACh-AFh
   localparam int PPI_SEL_LSB = 3;
   localparam logic [PORT_W-PPI_SEL_LSB-1:0] PPI_PORT_BASE = 5'b10101;

   // Pulled-up data bus when nobody drives it
   localparam logic [DATA_W-1:0] OPEN_BUS = 8'hFF;

endpackage

//--- hw/msx_io_decoder.sv
module msx_io_decoder (
   input  logic [msx_bus_pkg::ADDR_W-1:0] addr_i,
   input  logic                           iorq_i,
   input  logic                           m1_i,
   input  logic                           rd_i,
   input  logic [msx_bus_pkg::DATA_W-1:0] ppi_rdata_i,
   input  logic [msx_bus_pkg::DATA_W-1:0] ext_din_i,
   output logic                           ppi_cs_o,
   output logic [1:0]                     ppi_reg_o,
   output logic [msx_bus_pkg::DATA_W-1:0] din_o
);
   import msx_bus_pkg::*;

   logic io_cycle;
   logic ppi_hit;

   // Interrupt acknowledge also raises IORQ, but together with M1
   assign io_cycle = iorq_i & ~m1_i;

   // Only the low byte of the address carries the port number
   assign ppi_hit  = (addr_i[PORT_W-1:PPI_SEL_LSB] == PPI_PORT_BASE);
   assign ppi_cs_o = io_cycle & ppi_hit;

   // A1:A0 pick the PPI register
   assign ppi_reg_o = addr_i[1:0];

   // Read return path shared by the PPI and the external devices
   // The port address alone decides who owns it
   always_comb begin
      if (!rd_i) begin
         din_o = OPEN_BUS;
      end else if (ppi_cs_o) begin
         din_o = ppi_rdata_i;
      end else begin
         // Everything else on the bus, memory reads included
         din_o = ext_din_i;
      end
   end

endmodule

//--- hw/msx_io_top.sv
module msx_io_top (
   input  logic                              clk21m,
   input  logic                              exwait_n,
   input  logic [msx_bus_pkg::ADDR_W-1:0]    addr_i,
   input  logic [msx_bus_pkg::DATA_W-1:0]    dout_i,
   input  logic                              iorq_i,
   input  logic                              rd_i,
   input  logic                              wr_i,
   input  logic                              m1_i,
   input  logic [msx_bus_pkg::DATA_W-1:0]    ext_din_i,
   input  logic                              kbd_we_i,
   input  logic [msx_ppi_pkg::KB_ROW_W-1:0]  kbd_row_i,
   input  logic [msx_bus_pkg::DATA_W-1:0]    kbd_data_i,
   output logic [msx_bus_pkg::DATA_W-1:0]    din_o,
   output logic [1:0]                        slot_o,
   output logic                              cas_motor_o,
   output logic                              keyclick_o
);
   import msx_bus_pkg::*;
   import msx_ppi_pkg::*;

   logic                ppi_cs;
   logic [1:0]          ppi_reg;
   logic [DATA_W-1:0]   ppi_rdata;
   logic [DATA_W-1:0]   kb_rdata;
   logic [DATA_W-1:0]   port_a;
   logic [DATA_W-1:0]   port_c;
   logic [KB_ROW_W-1:0] kb_row;
   logic                ppi_touched;

   msx_io_decoder u_decoder (
      .addr_i      (addr_i),
      .iorq_i      (iorq_i),
      .m1_i        (m1_i),
      .rd_i        (rd_i),
      .ppi_rdata_i (ppi_rdata),
      .ext_din_i   (ext_din_i),
      .ppi_cs_o    (ppi_cs),
      .ppi_reg_o   (ppi_reg),
      .din_o       (din_o)
   );

   msx_ppi u_ppi (
      .clk21m     (clk21m),
      .exwait_n   (exwait_n),
      .cs_i       (ppi_cs),
      .reg_i      (ppi_reg),
      .wr_i       (wr_i),
      .rd_i       (rd_i),
      .wdata_i    (dout_i),
      .kb_rdata_i (kb_rdata),
      .rdata_o    (ppi_rdata),
      .port_a_o   (port_a),
      .port_c_o   (port_c),
      .touched_o  (ppi_touched)
   );

   // Low nibble of port C scans the keyboard
   assign kb_row = port_c[KB_ROW_W-1:0];

   msx_key_matrix u_key_matrix (
      .clk21m     (clk21m),
      .exwait_n   (exwait_n),
      .kbd_we_i   (kbd_we_i),
      .kbd_row_i  (kbd_row_i),
      .kbd_data_i (kbd_data_i),
      .scan_row_i (kb_row),
      .row_data_o (kb_rdata)
   );

   msx_slot_select u_slot_select (
      .clk21m    (clk21m),
      .exwait_n  (exwait_n),
      .port_a_i  (port_a),
      .touched_i (ppi_touched),
      .page_i    (addr_i[ADDR_W-1 -: 2]),
      .slot_o    (slot_o)
   );

   assign cas_motor_o = port_c[CAS_MOTOR_BIT];
   assign keyclick_o  = port_c[KEYCLICK_BIT];

endmodule

//--- hw/msx_key_matrix.sv
module msx_key_matrix (
   input  logic                              clk21m,
   input  logic                              exwait_n,
   input  logic                              kbd_we_i,
   input  logic [msx_ppi_pkg::KB_ROW_W-1:0]  kbd_row_i,
   input  logic [msx_bus_pkg::DATA_W-1:0]    kbd_data_i,
   input  logic [msx_ppi_pkg::KB_ROW_W-1:0]  scan_row_i,
   output logic [msx_bus_pkg::DATA_W-1:0]    row_data_o
);
   import msx_bus_pkg::*;
   import msx_ppi_pkg::*;

   // Keys are active low with one byte per row
   logic [DATA_W-1:0] rows_q [KB_ROWS];

   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         for (int r = 0; r < KB_ROWS; r++) begin
            rows_q[r] <= KB_IDLE;
         end
      end else if (kbd_we_i && (kbd_row_i < KB_ROWS)) begin
         rows_q[kbd_row_i] <= kbd_data_i;
      end
   end

   // Rows past the end of the matrix have no keys
   assign row_data_o = (scan_row_i < KB_ROWS) ? rows_q[scan_row_i] : KB_IDLE;

   // The host side only knows the real rows
   host_row_range: assert property (@(posedge clk21m) disable iff (!exwait_n)
      kbd_we_i |-> (kbd_row_i < KB_ROWS))
      else $error("keyboard write to row %0d", kbd_row_i);

endmodule

//--- hw/msx_ppi.sv
module msx_ppi (
   input  logic                           clk21m,
   input  logic                           exwait_n,
   input  logic                           cs_i,
   input  logic [1:0]                     reg_i,
   input  logic                           wr_i,
   input  logic                           rd_i,
   input  logic [msx_bus_pkg::DATA_W-1:0] wdata_i,
   input  logic [msx_bus_pkg::DATA_W-1:0] kb_rdata_i,
   output logic [msx_bus_pkg::DATA_W-1:0] rdata_o,
   output logic [msx_bus_pkg::DATA_W-1:0] port_a_o,
   output logic [msx_bus_pkg::DATA_W-1:0] port_c_o,
   output logic                           touched_o
);
   import msx_ppi_pkg::*;

   logic [7:0] port_a_q;
   logic [7:0] port_c_q;
   ppi_ctrl_u  ctrl_q;
   ppi_ctrl_u  ctrl_w;
   logic       wr_sel;
   logic       wr_sel_q;
   logic       wr_pulse;
   logic       access;
   logic       touched_q;

   assign ctrl_w = wdata_i;

   // One write per strobe, however long the CPU holds it
   assign wr_sel   = cs_i & wr_i;
   assign wr_pulse = wr_sel & ~wr_sel_q;

   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         wr_sel_q <= 1'b0;
      end else begin
         wr_sel_q <= wr_sel;
      end
   end

   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         port_a_q <= '0;
         port_c_q <= '0;
         ctrl_q   <= PPI_CTRL_INIT;
      end else if (wr_pulse) begin
         case (reg_i)
            PPI_REG_A: port_a_q <= wdata_i;
            PPI_REG_C: port_c_q <= wdata_i;
            PPI_REG_CTRL: begin
               ctrl_q <= ctrl_w;
               if (ctrl_w.mode.mode_set) begin
                  // A new mode clears the output latches
                  port_a_q <= '0;
                  port_c_q <= '0;
               end else begin
                  port_c_q[ctrl_w.bsr.bit_sel] <= ctrl_w.bsr.bit_val;
               end
            end
            // Port B is the keyboard input and ignores writes
            default: ;
         endcase
      end
   end

   // Read data is steered onto the bus by the decoder
   always_comb begin
      case (reg_i)
         PPI_REG_A: rdata_o = port_a_q;
         PPI_REG_B: rdata_o = kb_rdata_i;
         PPI_REG_C: rdata_o = port_c_q;
         default:   rdata_o = ctrl_q;
      endcase
   end

   // Sticky once the CPU has talked to the PPI
   assign access = cs_i & (rd_i | wr_i);

   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         touched_q <= 1'b0;
      end else if (access) begin
         touched_q <= 1'b1;
      end
   end

   // Include the current access so the slot map arms on the same edge as the write
   assign touched_o = touched_q | access;

   assign port_a_o = port_a_q;
   assign port_c_o = port_c_q;

   // The Z80 never reads and writes in one I/O cycle
   rd_wr_excl: assert property (@(posedge clk21m) disable iff (!exwait_n)
      cs_i |-> !(rd_i && wr_i))
      else $error("PPI selected with rd_i and wr_i both high");

endmodule

//--- hw/msx_ppi_pkg.sv
package msx_ppi_pkg;

   // Mode-set view of the control byte
   typedef struct packed {
      logic       mode_set;
      logic [1:0] grp_a_mode;
      logic       port_a_in;
      logic       port_c_hi_in;
      logic       grp_b_mode;
      logic       port_b_in;
      logic       port_c_lo_in;
   } ppi_mode_t;

   // Bit set/reset view used when bit 7 is clear
   typedef struct packed {
      logic       mode_set;
      logic [2:0] unused;
      logic [2:0] bit_sel;
      logic       bit_val;
   } ppi_bsr_t;

   typedef union packed {
      ppi_mode_t mode;
      ppi_bsr_t  bsr;
   } ppi_ctrl_u;

   // Register index from A1:A0
   localparam logic [1:0] PPI_REG_A    = 2'd0;
   localparam logic [1:0] PPI_REG_B    = 2'd1;
   localparam logic [1:0] PPI_REG_C    = 2'd2;
   localparam logic [1:0] PPI_REG_CTRL = 2'd3;

   // Mode 0 with A and C as outputs and B as input, as the BIOS sets it
   localparam ppi_ctrl_u PPI_CTRL_INIT = 8'h82;

   // Keyboard matrix
   localparam int KB_ROWS  = 11;
   localparam int KB_ROW_W = 4;
   localparam logic [7:0] KB_IDLE = 8'hFF;

   // Port C outputs
   localparam int CAS_MOTOR_BIT = 4;
   localparam int KEYCLICK_BIT  = 7;

endpackage

//--- hw/msx_slot_select.sv
module msx_slot_select (
   input  logic                           clk21m,
   input  logic                           exwait_n,
   input  logic [msx_bus_pkg::DATA_W-1:0] port_a_i,
   input  logic                           touched_i,
   input  logic [1:0]                     page_i,
   output logic [1:0]                     slot_o
);

   logic map_valid_q;

   // Slot 0 everywhere until software has touched the PPI
   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         map_valid_q <= 1'b0;
      end else begin
         map_valid_q <= touched_i;
      end
   end

   // Port A holds two bits per 16 KB page, page 0 in the low bits
   always_comb begin
      if (!map_valid_q) begin
         slot_o = 2'b00;
      end else begin
         case (page_i)
            2'd0:    slot_o = port_a_i[1:0];
            2'd1:    slot_o = port_a_i[3:2];
            2'd2:    slot_o = port_a_i[5:4];
            default: slot_o = port_a_i[7:6];
         endcase
      end
   end

endmodule

//--- test/msx_io_stimulus.txt
# op addr data expected, all hex; op 0 io write, 1 io read, 2 key write, 3 page set, 4 held write
# read: data is ext_din, expected is din_o; key write: addr is row; others: expected {click,motor,0000,slot}
3 0000 00 00
3 c000 00 00
1 00a8 00 00
1 00aa 00 00
1 00a9 00 ff
0 00a8 e4 00
3 0000 00 00
3 4000 00 01
3 8000 00 02
3 c000 00 03
2 0003 5a ff
0 00aa 03 00
1 00a9 00 5a
2 000a 7e ff
0 00aa 0a 00
1 00a9 00 7e
0 00aa 0b 00
1 00a9 00 ff
0 00aa 0f 00
1 00a9 00 ff
0 00ab 09 40
0 00ab 0f c0
1 00aa 00 9f
0 00ab 82 00
1 00a8 00 00
1 00aa 00 00
3 c000 00 00
1 0099 3c 3c
1 00a0 55 55
0 c0a8 e4 03
0 c0ab 09 43
4 c0ab 08 03
1 00a8 00 e4
1 00aa 00 00
1 00ab 00 08

//--- test/tb_msx_io.sv
module tb_msx_io;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int CLK_PERIOD    = 20;
   localparam int RESET_CYCLES  = 16;
   localparam int CYCLES_PER_OP = 10;
   localparam string STIM_FILE  = "test/msx_io_stimulus.txt";

   // Operation codes of the stimulus file
   localparam logic [7:0] OP_IO_WR   = 8'd0;
   localparam logic [7:0] OP_IO_RD   = 8'd1;
   localparam logic [7:0] OP_KEY_WR  = 8'd2;
   localparam logic [7:0] OP_PAGE    = 8'd3;
   localparam logic [7:0] OP_HELD_WR = 8'd4;

   logic        clk21m;
   logic        exwait_n;
   logic [15:0] addr;
   logic [7:0]  dout;
   logic        iorq;
   logic        rd;
   logic        wr;
   logic        m1;
   logic [7:0]  ext_din;
   logic        kbd_we;
   logic [3:0]  kbd_row;
   logic [7:0]  kbd_data;
   logic [7:0]  din;
   logic [1:0]  slot;
   logic        cas_motor;
   logic        keyclick;

   int errors;
   int checks;
   int op_count;

   msx_io_top dut_i (
      .clk21m      (clk21m),
      .exwait_n    (exwait_n),
      .addr_i      (addr),
      .dout_i      (dout),
      .iorq_i      (iorq),
      .rd_i        (rd),
      .wr_i        (wr),
      .m1_i        (m1),
      .ext_din_i   (ext_din),
      .kbd_we_i    (kbd_we),
      .kbd_row_i   (kbd_row),
      .kbd_data_i  (kbd_data),
      .din_o       (din),
      .slot_o      (slot),
      .cas_motor_o (cas_motor),
      .keyclick_o  (keyclick)
   );

   initial begin
      clk21m = 1'b0;
      forever #(CLK_PERIOD / 2) clk21m = ~clk21m;
   end

   task automatic compare_value(input string name, input logic [7:0] got,
                                input logic [7:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic bus_idle();
      addr     = '0;
      dout     = '0;
      iorq     = 1'b0;
      rd       = 1'b0;
      wr       = 1'b0;
      m1       = 1'b0;
      ext_din  = '0;
      kbd_we   = 1'b0;
      kbd_row  = '0;
      kbd_data = '0;
   endtask

   // Status byte holds keyclick in bit 7, cassette motor in bit 6 and slot in bits 1:0
   task automatic check_status(input logic [7:0] exp);
      compare_value("slot_o", {6'b0, slot}, {6'b0, exp[1:0]});
      compare_value("cas_motor_o", {7'b0, cas_motor}, {7'b0, exp[6]});
      compare_value("keyclick_o", {7'b0, keyclick}, {7'b0, exp[7]});
   endtask

   // Flip makes the data change while the strobe is still held
   task automatic io_write(input logic [15:0] a, input logic [7:0] d,
                           input logic [7:0] exp, input int hold, input bit flip);
      addr = a;
      dout = d;
      iorq = 1'b1;
      wr   = 1'b1;
      for (int i = 0; i < hold; i++) begin
         @(negedge clk21m);
         if (flip) begin
            dout = ~d;
         end
      end
      iorq = 1'b0;
      wr   = 1'b0;
      #(CLK_PERIOD / 4);
      check_status(exp);
      @(negedge clk21m);
      bus_idle();
   endtask

   task automatic io_read(input logic [15:0] a, input logic [7:0] ext, input logic [7:0] exp);
      addr    = a;
      ext_din = ext;
      iorq    = 1'b1;
      rd      = 1'b1;
      #(CLK_PERIOD / 4);
      compare_value("din_o", din, exp);
      @(negedge clk21m);
      bus_idle();
   endtask

   // With rd low the bus must float high
   task automatic key_write(input logic [3:0] row, input logic [7:0] d, input logic [7:0] exp);
      kbd_we   = 1'b1;
      kbd_row  = row;
      kbd_data = d;
      @(negedge clk21m);
      kbd_we = 1'b0;
      #(CLK_PERIOD / 4);
      compare_value("din_o", din, exp);
      @(negedge clk21m);
      bus_idle();
   endtask

   task automatic page_set(input logic [15:0] a, input logic [7:0] exp);
      addr = a;
      #(CLK_PERIOD / 4);
      check_status(exp);
      @(negedge clk21m);
      bus_idle();
   endtask

   task automatic count_ops(output int n);
      string line;
      int    fd;
      int    code;
      n  = 0;
      fd = $fopen(STIM_FILE, "r");
      if (fd != 0) begin
         while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code == 0) break;
            if (line.len() >= 2 && line[0] != 8'h23) n++;
         end
         $fclose(fd);
      end
   endtask

   initial begin
      string       line;
      int          fd;
      int          code;
      int          n_fields;
      int          err_before;
      int          test_no;
      logic [7:0]  op;
      logic [15:0] a;
      logic [7:0]  d;
      logic [7:0]  exp;
      errors   = 0;
      checks   = 0;
      test_no  = 0;
      exwait_n = 1'b0;
      bus_idle();
      count_ops(op_count);
      repeat (RESET_CYCLES) @(negedge clk21m);
      exwait_n = 1'b1;
      @(negedge clk21m);
      fd = $fopen(STIM_FILE, "r");
      if (fd == 0) begin
         $display("could not open the stimulus file %s", STIM_FILE);
         errors++;
      end else begin
         while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code == 0) break;
            if (line.len() < 2 || line[0] == 8'h23) continue;
            n_fields = $sscanf(line, "%h %h %h %h", op, a, d, exp);
            test_no++;
            err_before = errors;
            if (n_fields != 4) begin
               $display("test %0d has %0d fields instead of four", test_no, n_fields);
               errors++;
            end else begin
               case (op)
                  OP_IO_WR:   io_write(a, d, exp, 2, 1'b0);
                  OP_IO_RD:   io_read(a, d, exp);
                  OP_KEY_WR:  key_write(a[3:0], d, exp);
                  OP_PAGE:    page_set(a, exp);
                  OP_HELD_WR: io_write(a, d, exp, 6, 1'b1);
                  default: begin
                     $display("test %0d uses an unknown operation %0d", test_no, op);
                     errors++;
                  end
               endcase
            end
            $display("test %0d: op %0d addr %h data %h %s", test_no, op, a, d,
                     (errors == err_before) ? "ok" : "failed");
         end
         $fclose(fd);
      end
      $display("tests %0d, checks %0d, errors %0d", test_no, checks, errors);
      if (errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

   // Budget grows with the number of operations in the file
   initial begin
      wait (op_count > 0);
      #((op_count * CYCLES_PER_OP + RESET_CYCLES) * CLK_PERIOD);
      $display("watchdog expired before all stimulus lines were run");
      $display("=== FAIL ===");
      $finish;
   end

endmodule
